/* Bender.yml */
package:
  name: ctrl_unit

sources:
  - files:
      - src/ctrlPkg.sv
      - src/decodedInstrIf.sv
      - src/instrDecoder.sv
      - src/aluCtrl.sv
      - src/memStackCtrl.sv
      - src/flowFlagCtrl.sv
      - src/ctrlUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/ctrlUnitTb.sv

/* src/aluCtrl.sv */
// ALU and register write-back control.
// Picks the ALU operation and operand source from the decoded instruction and
// raises the write-back enables. Idle instructions leave the ALU on MOV.
`timescale 1ns/1ps

module aluCtrl (
	decodedInstr_if.gen dec,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::aluSrc_t aluSrc,
	output logic regLowWrite,
	output logic regHighWrite,
	output logic memToReg
);
	import ctrlPkg::*;

	logic isAluKind;	// any of the twelve register ALU instructions
	logic isPop;

	always_comb begin
		case (dec.kind)
			ADD: aluOp = ALU_ADD;
			SUB: aluOp = ALU_SUB;
			MUL: aluOp = ALU_MUL;
			DIV: aluOp = ALU_DIV;
			SHL: aluOp = ALU_SHL;
			SHR: aluOp = ALU_SHR;
			INC: aluOp = ALU_INC;
			DEC: aluOp = ALU_DEC;
			AND: aluOp = ALU_AND;
			OR: aluOp = ALU_OR;
			NOT: aluOp = ALU_NOT;
			default: aluOp = ALU_MOV;	// MOV and every non-ALU kind
		endcase
	end

	always_comb begin
		if (dec.kind == LDM)
			aluSrc = ALU_SRC_DATA;	// immediate word passes through
		else if (dec.kind inside {SHL, SHR})
			aluSrc = ALU_SRC_SHMT;
		else
			aluSrc = ALU_SRC_REG;
	end

	assign isAluKind = dec.kind inside {ADD, SUB, MUL, DIV, SHL, SHR, INC, DEC,
		AND, OR, NOT, MOV};
	assign isPop = (dec.kind == POP);

	// pop of the PC goes to the PC, not to Rdst
	assign regLowWrite = isAluKind | (dec.kind inside {IN, LDD, LDM})
		| (isPop & ~dec.stackPc);
	assign regHighWrite = (dec.kind == MUL);	// upper half of product
	// plain pop only, PC and flags pops bypass the register file
	assign memToReg = (dec.kind inside {LDD, IN})
		| (isPop & ~(dec.stackPc | dec.stackFlags));

endmodule

/* src/ctrlPkg.sv */
// Shared types and codes of the instruction-decoding control unit.
// Holds the field widths, ALU operation codes, select codes and the decoded
// instruction enum. Modules pull it in with a wildcard import in their body.
package ctrlPkg;

	localparam int INSTR_W  = 16;	// instruction word width
	localparam int OPCODE_W = 4;	// major opcode, top bits of the word
	localparam int FUNCT_W  = 3;	// function field, bottom bits of the word

	typedef logic [INSTR_W-1:0]  instrWord_t;
	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [FUNCT_W-1:0]  funct_t;	// 2-bit groups use only [1:0]
	typedef logic [3:0]          aluOp_t;
	typedef logic [1:0]          aluSrc_t;
	typedef logic [1:0]          jmpType_t;
	typedef logic [1:0]          spSrc_t;

	// ALU operation codes as the execute stage expects them
	localparam aluOp_t ALU_ADD = 4'd0;
	localparam aluOp_t ALU_SUB = 4'd1;
	localparam aluOp_t ALU_INC = 4'd2;
	localparam aluOp_t ALU_DEC = 4'd3;
	localparam aluOp_t ALU_AND = 4'd4;
	localparam aluOp_t ALU_OR  = 4'd5;
	localparam aluOp_t ALU_NOT = 4'd6;
	localparam aluOp_t ALU_SHL = 4'd7;
	localparam aluOp_t ALU_SHR = 4'd8;
	localparam aluOp_t ALU_MUL = 4'd9;
	localparam aluOp_t ALU_DIV = 4'd10;
	localparam aluOp_t ALU_MOV = 4'd11;	// also the idle operation

	localparam aluSrc_t ALU_SRC_REG  = 2'd0;	// second operand from register file
	localparam aluSrc_t ALU_SRC_DATA = 2'd1;	// 16-bit word after LDM
	localparam aluSrc_t ALU_SRC_SHMT = 2'd2;	// shift amount field

	localparam jmpType_t JMP_ALWAYS = 2'd0;
	localparam jmpType_t JMP_CARRY  = 2'd1;
	localparam jmpType_t JMP_NEG    = 2'd2;
	localparam jmpType_t JMP_ZERO   = 2'd3;

	localparam spSrc_t SP_KEEP = 2'd0;
	localparam spSrc_t SP_DEC  = 2'd1;	// pop side
	localparam spSrc_t SP_INC  = 2'd2;	// push and call side

	// major opcodes, 12 to 15 reserved
	localparam opcode_t OPC_NOP      = 4'd0;
	localparam opcode_t OPC_ARITH    = 4'd1;
	localparam opcode_t OPC_SHIFT    = 4'd2;
	localparam opcode_t OPC_LOGIC    = 4'd3;
	localparam opcode_t OPC_BRANCH   = 4'd4;
	localparam opcode_t OPC_FLAG     = 4'd5;
	localparam opcode_t OPC_STACK    = 4'd6;
	localparam opcode_t OPC_MEM      = 4'd7;
	localparam opcode_t OPC_IMM      = 4'd8;
	localparam opcode_t OPC_CLRFLAGS = 4'd9;
	localparam opcode_t OPC_CALL     = 4'd10;
	localparam opcode_t OPC_SWINT    = 4'd11;

	localparam int OP_BIT    = 11;	// set (1) or clear (0) on flag ops
	localparam int PC_BIT    = 8;	// push/pop the PC
	localparam int FLAGS_BIT = 7;	// push/pop the flags

	// 33 instructions, so six bits are needed to hold the code
	typedef enum logic [5:0] {
		KIND_NONE,
		ADD, SUB, MUL, DIV,
		SHL, SHR, INC, DEC,
		AND, OR, NOT, MOV,
		JZ, JN, JC, JMP,	// jump to register
		FLAGOP,
		PUSH, POP,
		OUT, IN, LDD, STD,
		LDM,
		CALLI, JMPI, JCI, JNI, JZI,	// immediate target
		CLRALL, CALLR, SWINT
	} instrKind_t;

endpackage

/* src/ctrlUnit.sv */
// Top level of the instruction-decoding control unit.
// Takes one 16-bit instruction word and returns every control strobe and
// select of the datapath in the same cycle. Pure combinational logic.
`timescale 1ns/1ps

module ctrlUnit (
	input ctrlPkg::instrWord_t instruction,
	output ctrlPkg::aluOp_t aluOp,
	output ctrlPkg::aluSrc_t aluSrc,
	output logic regLowWrite,
	output logic regHighWrite,
	output logic memToReg,
	output logic memWrite,
	output logic memRead,
	output logic portWrite,
	output logic portRead,
	output logic memType,
	output logic pcPushPop,
	output logic flagsPushPop,
	output ctrlPkg::spSrc_t spSrc,
	output logic memDataSrc,
	output logic memAddressSrc,
	output logic isJmp,
	output ctrlPkg::jmpType_t jmpType,
	output logic jmpSrc,
	output logic setZ,
	output logic setN,
	output logic setC,
	output logic setOvf,
	output logic clrZ,
	output logic clrN,
	output logic clrC,
	output logic clrOvf,
	output logic setInt
);
	import ctrlPkg::*;

	decodedInstr_if decBus ();	// decoder to generators

	instrDecoder instrDecoder_i (
		.instr (instruction),
		.dec   (decBus)
	);

	aluCtrl aluCtrl_i (
		.dec          (decBus),
		.aluOp        (aluOp),
		.aluSrc       (aluSrc),
		.regLowWrite  (regLowWrite),
		.regHighWrite (regHighWrite),
		.memToReg     (memToReg)
	);

	memStackCtrl memStackCtrl_i (
		.dec           (decBus),
		.memWrite      (memWrite),
		.memRead       (memRead),
		.portWrite     (portWrite),
		.portRead      (portRead),
		.memType       (memType),
		.pcPushPop     (pcPushPop),
		.flagsPushPop  (flagsPushPop),
		.spSrc         (spSrc),
		.memDataSrc    (memDataSrc),
		.memAddressSrc (memAddressSrc)
	);

	flowFlagCtrl flowFlagCtrl_i (
		.dec     (decBus),
		.isJmp   (isJmp),
		.jmpType (jmpType),
		.jmpSrc  (jmpSrc),
		.setZ    (setZ),
		.setN    (setN),
		.setC    (setC),
		.setOvf  (setOvf),
		.clrZ    (clrZ),
		.clrN    (clrN),
		.clrC    (clrC),
		.clrOvf  (clrOvf),
		.setInt  (setInt)
	);

endmodule

/* src/decodedInstrIf.sv */
// Decoded instruction bundle from the decoder to the control generators.
// The decoder drives it through dec, the generators read it through gen.
`timescale 1ns/1ps

interface decodedInstr_if;

	ctrlPkg::instrKind_t kind;	// one code per instruction
	logic [1:0] flagSel;	// low funct bits, picks Z N C Ovf
	logic opSet;	// set/clear modifier of flag ops
	logic stackPc;	// PC modifier of push/pop
	logic stackFlags;	// flags modifier of push/pop

	modport dec (
		output kind, flagSel, opSet, stackPc, stackFlags
	);

	// read side shared by all three generators
	modport gen (
		input kind, flagSel, opSet, stackPc, stackFlags
	);

endinterface

/* src/flowFlagCtrl.sv */
// Program flow and flag control.
// Flags jumps and calls with their condition and target source, drives the
// individual flag set/clear strobes and raises the software interrupt.
`timescale 1ns/1ps

module flowFlagCtrl (
	decodedInstr_if.gen dec,
	output logic isJmp,
	output ctrlPkg::jmpType_t jmpType,
	output logic jmpSrc,
	output logic setZ,
	output logic setN,
	output logic setC,
	output logic setOvf,
	output logic clrZ,
	output logic clrN,
	output logic clrC,
	output logic clrOvf,
	output logic setInt
);
	import ctrlPkg::*;

	logic [3:0] flagHot;	// bit 0 Z, 1 N, 2 C, 3 Ovf
	logic [3:0] setVec;
	logic [3:0] clrVec;
	logic isFlagOp;
	logic isRti;	// pop of PC and flags together

	assign isJmp = dec.kind inside {JZ, JN, JC, JMP, CALLR,
		CALLI, JMPI, JCI, JNI, JZI};
	// target word follows the instruction for every I-type kind
	assign jmpSrc = dec.kind inside {LDM, CALLI, JMPI, JCI, JNI, JZI};

	always_comb begin
		if (dec.kind inside {JC, JCI})
			jmpType = JMP_CARRY;
		else if (dec.kind inside {JN, JNI})
			jmpType = JMP_NEG;
		else if (dec.kind inside {JZ, JZI})
			jmpType = JMP_ZERO;
		else
			jmpType = JMP_ALWAYS;
	end

	assign isFlagOp = (dec.kind == FLAGOP);
	assign isRti    = (dec.kind == POP) & dec.stackPc & dec.stackFlags;
	assign flagHot  = 4'b0001 << dec.flagSel;

	assign setVec = {4{isFlagOp & dec.opSet}} & flagHot;
	assign clrVec = ({4{isFlagOp & ~dec.opSet}} & flagHot)
		| {4{dec.kind == CLRALL}}
		| {isRti, 3'b000};	// return drops overflow

	assign {setOvf, setC, setN, setZ} = setVec;
	assign {clrOvf, clrC, clrN, clrZ} = clrVec;

	assign setInt = (dec.kind == SWINT);

endmodule

/* src/instrDecoder.sv */
// Instruction classifier, the only block that looks at opcode and funct.
// Every legal opcode/funct pair becomes one instrKind_t code, anything else
// (NOP, reserved opcodes, unused funct values) comes out as KIND_NONE.
`timescale 1ns/1ps

module instrDecoder (
	input ctrlPkg::instrWord_t instr,
	decodedInstr_if.dec dec
);
	import ctrlPkg::*;

	opcode_t opcode;
	funct_t funct;
	instrKind_t kind;

	assign opcode = instr[INSTR_W-1 -: OPCODE_W];	// bits 15..12
	assign funct  = instr[FUNCT_W-1:0];	// bits 2..0

	always_comb begin
		kind = KIND_NONE;
		case (opcode)
			OPC_NOP: kind = KIND_NONE;
			OPC_ARITH: begin
				case (funct[1:0])
					2'd0: kind = DIV;
					2'd1: kind = MUL;
					2'd2: kind = ADD;
					default: kind = SUB;
				endcase
			end
			OPC_SHIFT: begin
				case (funct[1:0])
					2'd0: kind = SHL;
					2'd1: kind = SHR;
					2'd2: kind = INC;
					default: kind = DEC;
				endcase
			end
			OPC_LOGIC: begin	// OR comes before AND in this group
				case (funct[1:0])
					2'd0: kind = OR;
					2'd1: kind = AND;
					2'd2: kind = NOT;
					default: kind = MOV;
				endcase
			end
			OPC_BRANCH: begin
				case (funct[1:0])
					2'd0: kind = JZ;
					2'd1: kind = JN;
					2'd2: kind = JC;
					default: kind = JMP;
				endcase
			end
			OPC_FLAG: kind = FLAGOP;	// flag and direction come from modifiers
			OPC_STACK: begin
				if (funct[1:0] == 2'd0)
					kind = PUSH;
				else if (funct[1:0] == 2'd1)
					kind = POP;	// funct 2 and 3 unused
			end
			OPC_MEM: begin
				case (funct[1:0])
					2'd0: kind = OUT;
					2'd1: kind = IN;
					2'd2: kind = LDD;
					default: kind = STD;
				endcase
			end
			OPC_IMM: begin	// full 3-bit funct here
				case (funct)
					3'd0: kind = LDM;
					3'd1: kind = CALLI;
					3'd2: kind = JMPI;
					3'd3: kind = JCI;
					3'd4: kind = JNI;
					3'd5: kind = JZI;
					default: kind = KIND_NONE;	// 6 and 7 reserved
				endcase
			end
			OPC_CLRFLAGS: kind = CLRALL;
			OPC_CALL: kind = CALLR;
			OPC_SWINT: kind = SWINT;
			default: kind = KIND_NONE;	// opcodes 12..15
		endcase
	end

	assign dec.kind       = kind;
	assign dec.flagSel    = funct[1:0];
	assign dec.opSet      = instr[OP_BIT];
	assign dec.stackPc    = instr[PC_BIT];
	assign dec.stackFlags = instr[FLAGS_BIT];

endmodule

/* src/memStackCtrl.sv */
// Data memory, port and stack control.
// Produces the memory and port strobes, the stack pointer action and the
// data/address selects used by push, pop and both call forms.
`timescale 1ns/1ps

module memStackCtrl (
	decodedInstr_if.gen dec,
	output logic memWrite,
	output logic memRead,
	output logic portWrite,
	output logic portRead,
	output logic memType,
	output logic pcPushPop,
	output logic flagsPushPop,
	output ctrlPkg::spSrc_t spSrc,
	output logic memDataSrc,
	output logic memAddressSrc
);
	import ctrlPkg::*;

	logic isPush;
	logic isPop;
	logic isCall;	// immediate or register call
	logic isStackOp;

	assign isPush    = (dec.kind == PUSH);
	assign isPop     = (dec.kind == POP);
	assign isCall    = dec.kind inside {CALLI, CALLR};
	assign isStackOp = isPush | isPop;

	assign memWrite = isPush | isCall | (dec.kind == STD);	// call stores return PC
	assign memRead  = isPop | (dec.kind == LDD);
	assign memType  = memWrite | memRead;	// data memory rather than ports

	assign portWrite = (dec.kind == OUT);
	assign portRead  = (dec.kind == IN);

	assign pcPushPop    = (isStackOp & dec.stackPc) | isCall;
	assign flagsPushPop = isStackOp & dec.stackFlags;

	// stack grows upward in this machine
	always_comb begin
		if (isPop)
			spSrc = SP_DEC;
		else if (isPush | isCall)
			spSrc = SP_INC;
		else
			spSrc = SP_KEEP;
	end

	// store PC/flags instead of Rdst
	assign memDataSrc = (isPush & (dec.stackPc | dec.stackFlags)) | isCall;
	// address from SP instead of Rsrc
	assign memAddressSrc = isStackOp | isCall;

endmodule

/* include/ctrlUnitVectors.svh */
// Expected control outputs for a set of instruction words.
// Include inside the testbench module body; one row per instruction word.
// reg = {regLowWrite, regHighWrite, memToReg}
// mem = {memWrite, memRead, portWrite, portRead, memType, pcPushPop, flagsPushPop}
// sp = {spSrc, memDataSrc, memAddressSrc}, jmp = {isJmp, jmpType, jmpSrc}
`ifndef CTRL_UNIT_VECTORS_SVH
`define CTRL_UNIT_VECTORS_SVH

typedef struct packed {
	logic [15:0] instr;
	logic [3:0]  aluOp;
	logic [1:0]  aluSrc;
	logic [2:0]  reg3;
	logic [6:0]  mem;
	logic [3:0]  sp;
	logic [3:0]  jmp;
	logic [7:0]  flg;	// set Z N C Ovf, then clr Z N C Ovf
	logic        setInt;
} ctrlVector_t;

localparam int NUM_VECTORS = 46;

localparam ctrlVector_t CTRL_VECTORS [NUM_VECTORS] = '{
	'{16'h1248, 4'ha, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // DIV
	'{16'h1249, 4'h9, 2'd0, 3'b110, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // MUL
	'{16'h124a, 4'h0, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // ADD
	'{16'h124b, 4'h1, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // SUB
	'{16'h2214, 4'h7, 2'd2, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // SHL
	'{16'h2215, 4'h8, 2'd2, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // SHR
	'{16'h2216, 4'h2, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // INC
	'{16'h2217, 4'h3, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // DEC
	'{16'h3640, 4'h5, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // OR
	'{16'h3641, 4'h4, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // AND
	'{16'h3642, 4'h6, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // NOT
	'{16'h3643, 4'hb, 2'd0, 3'b100, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // MOV
	'{16'h8200, 4'hb, 2'd1, 3'b100, 7'b0000000, 4'b0000, 4'b0001, 8'b00000000, 1'b0}, // LDM
	'{16'h6200, 4'hb, 2'd0, 3'b000, 7'b1000100, 4'b1001, 4'b0000, 8'b00000000, 1'b0}, // PUSH
	'{16'h6300, 4'hb, 2'd0, 3'b000, 7'b1000110, 4'b1011, 4'b0000, 8'b00000000, 1'b0}, // PUSH PC
	'{16'h6280, 4'hb, 2'd0, 3'b000, 7'b1000101, 4'b1011, 4'b0000, 8'b00000000, 1'b0}, // PUSH F
	'{16'h6380, 4'hb, 2'd0, 3'b000, 7'b1000111, 4'b1011, 4'b0000, 8'b00000000, 1'b0}, // PUSH PC F
	'{16'h6201, 4'hb, 2'd0, 3'b101, 7'b0100100, 4'b0101, 4'b0000, 8'b00000000, 1'b0}, // POP
	'{16'h6301, 4'hb, 2'd0, 3'b000, 7'b0100110, 4'b0101, 4'b0000, 8'b00000000, 1'b0}, // POP PC
	'{16'h6281, 4'hb, 2'd0, 3'b100, 7'b0100101, 4'b0101, 4'b0000, 8'b00000000, 1'b0}, // POP F
	'{16'h6381, 4'hb, 2'd0, 3'b000, 7'b0100111, 4'b0101, 4'b0000, 8'b00000001, 1'b0}, // RTI
	'{16'h7210, 4'hb, 2'd0, 3'b000, 7'b0010000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // OUT
	'{16'h7211, 4'hb, 2'd0, 3'b101, 7'b0001000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // IN
	'{16'h7212, 4'hb, 2'd0, 3'b101, 7'b0100100, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // LDD
	'{16'h7213, 4'hb, 2'd0, 3'b000, 7'b1000100, 4'b0000, 4'b0000, 8'b00000000, 1'b0}, // STD
	'{16'h8001, 4'hb, 2'd0, 3'b000, 7'b1000110, 4'b1011, 4'b1001, 8'b00000000, 1'b0}, // CALLI
	'{16'ha200, 4'hb, 2'd0, 3'b000, 7'b1000110, 4'b1011, 4'b1000, 8'b00000000, 1'b0}, // CALLR
	'{16'h4200, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b1110, 8'b00000000, 1'b0}, // JZ
	'{16'h4201, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b1100, 8'b00000000, 1'b0}, // JN
	'{16'h4202, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b1010, 8'b00000000, 1'b0}, // JC
	'{16'h4203, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b1000, 8'b00000000, 1'b0}, // JMP
	'{16'h8002, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b1001, 8'b00000000, 1'b0}, // JMPI
	'{16'h8003, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b1011, 8'b00000000, 1'b0}, // JCI
	'{16'h8004, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b1101, 8'b00000000, 1'b0}, // JNI
	'{16'h8005, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b1111, 8'b00000000, 1'b0}, // JZI
	'{16'h5000, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00001000, 1'b0}, // CLRZ
	'{16'h5001, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00000100, 1'b0}, // CLRN
	'{16'h5002, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00000010, 1'b0}, // CLRC
	'{16'h5003, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00000001, 1'b0}, // CLROVF
	'{16'h5800, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b10000000, 1'b0}, // SETZ
	'{16'h5801, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b01000000, 1'b0}, // SETN
	'{16'h5802, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00100000, 1'b0}, // SETC
	'{16'h5803, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00010000, 1'b0}, // SETOVF
	'{16'h9000, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00001111, 1'b0}, // CLRALL
	'{16'hb000, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b1}, // SWINT
	'{16'h0000, 4'hb, 2'd0, 3'b000, 7'b0000000, 4'b0000, 4'b0000, 8'b00000000, 1'b0}  // NOP
};

`endif

/* verification/ctrlUnitTb.sv */
// Testbench for the control unit. Walks the vector table on a free-running clock,
// then feeds LFSR-random words with reserved opcodes and expects an idle decode.
// Inputs change on the falling edge and outputs are sampled on the rising edge.
`timescale 1ns/1ps

module ctrlUnitTb;
	import ctrlPkg::*;

	`include "ctrlUnitVectors.svh"

	localparam int EDGE_LIMIT  = 4;	// clock changes allowed per edge wait
	localparam int NUM_RANDOM  = 20;
	localparam int RESET_CYCLES = 5;
	localparam int RESET_LIMIT = RESET_CYCLES + 2;	// rising edges allowed for release

	logic clk;
	logic arstN;	// paces the start of the stimulus
	instrWord_t instruction;
	aluOp_t aluOp;
	aluSrc_t aluSrc;
	logic regLowWrite, regHighWrite, memToReg;
	logic memWrite, memRead, portWrite, portRead, memType;
	logic pcPushPop, flagsPushPop;
	spSrc_t spSrc;
	logic memDataSrc, memAddressSrc;
	logic isJmp;
	jmpType_t jmpType;
	logic jmpSrc;
	logic setZ, setN, setC, setOvf;
	logic clrZ, clrN, clrC, clrOvf;
	logic setInt;
	logic [15:0] lfsrState;	// random source state

	ctrlUnit ctrlUnit_i (.*);

	always #20 clk = ~clk;	// 40 ns period

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped after first failure");
	endtask

	// bounded wait for the next edge of the given direction
	task automatic waitEdge(input logic rising);
		int changes;
		changes = 0;
		do begin
			@(clk);
			changes++;
		end while (clk !== rising && changes < EDGE_LIMIT);
		if (clk !== rising)
			stopWithFailure("clock edge did not arrive in time");
	endtask

	// bounded wait until the reset generator lets go
	task automatic waitResetRelease();
		int cycles;
		cycles = 0;
		while (arstN !== 1'b1 && cycles < RESET_LIMIT) begin
			waitEdge(1'b1);
			cycles++;
		end
		if (arstN !== 1'b1)
			stopWithFailure("reset was not released in time");
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Error %s for instruction 0x%04h: expected 0x%0h, got 0x%0h",
				name, instruction, expected, actual));
	endtask

	task automatic checkOutputs(input ctrlVector_t v);
		checkValue("aluOp", v.aluOp, aluOp);
		checkValue("aluSrc", v.aluSrc, aluSrc);
		checkValue("regLowWrite", v.reg3[2], regLowWrite);
		checkValue("regHighWrite", v.reg3[1], regHighWrite);
		checkValue("memToReg", v.reg3[0], memToReg);
		checkValue("memWrite", v.mem[6], memWrite);
		checkValue("memRead", v.mem[5], memRead);
		checkValue("portWrite", v.mem[4], portWrite);
		checkValue("portRead", v.mem[3], portRead);
		checkValue("memType", v.mem[2], memType);
		checkValue("pcPushPop", v.mem[1], pcPushPop);
		checkValue("flagsPushPop", v.mem[0], flagsPushPop);
		checkValue("spSrc", v.sp[3:2], spSrc);
		checkValue("memDataSrc", v.sp[1], memDataSrc);
		checkValue("memAddressSrc", v.sp[0], memAddressSrc);
		checkValue("isJmp", v.jmp[3], isJmp);
		checkValue("jmpType", v.jmp[2:1], jmpType);
		checkValue("jmpSrc", v.jmp[0], jmpSrc);
		checkValue("setZ", v.flg[7], setZ);
		checkValue("setN", v.flg[6], setN);
		checkValue("setC", v.flg[5], setC);
		checkValue("setOvf", v.flg[4], setOvf);
		checkValue("clrZ", v.flg[3], clrZ);
		checkValue("clrN", v.flg[2], clrN);
		checkValue("clrC", v.flg[1], clrC);
		checkValue("clrOvf", v.flg[0], clrOvf);
		checkValue("setInt", v.setInt, setInt);
	endtask

	// drive on the falling edge, sample a half period later
	task automatic runVector(input ctrlVector_t v);
		waitEdge(1'b0);
		instruction = v.instr;
		waitEdge(1'b1);
		checkOutputs(v);
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1, new bit enters at bit 0
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic getRandomWord(output logic [15:0] w);
		w = '0;
		for (int b = 0; b < 16; b++) begin
			lfsrState = lfsrNext(lfsrState);	// one step per bit
			w = {w[14:0], lfsrState[0]};
		end
	endtask

	// reset held low for a fixed number of cycles, released on a falling edge
	initial begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) waitEdge(1'b1);
		waitEdge(1'b0);
		arstN = 1'b1;
	end

	initial begin
		ctrlVector_t idle;
		logic [15:0] word;
		clk = 1'b0;
		instruction = '0;
		lfsrState = 16'd8;
		waitResetRelease();

		for (int i = 0; i < NUM_VECTORS; i++)
			runVector(CTRL_VECTORS[i]);

		// opcodes 12..15 decode to nothing
		for (int i = 0; i < NUM_RANDOM; i++) begin
			getRandomWord(word);
			word[15:14] = 2'b11;
			idle = '0;
			idle.instr = word;
			idle.aluOp = ALU_MOV;	// idle ALU operation
			runVector(idle);
		end

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+include
src/ctrlPkg.sv
src/decodedInstrIf.sv
src/instrDecoder.sv
src/aluCtrl.sv
src/memStackCtrl.sv
src/flowFlagCtrl.sv
src/ctrlUnit.sv
verification/ctrlUnitTb.sv
